/* core_pkg.sv */
package core_pkg;

	// datapath and register index widths
	parameter int XLEN   = 32;
	parameter int REG_AW = 5;

	// pc after reset
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	// alu functions
	// encoding loosely follows {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b1000,
		ALU_SLL = 4'b0001,
		ALU_SLT = 4'b0010,
		ALU_XOR = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_SRA = 4'b1101,
		ALU_OR  = 4'b0110,
		ALU_AND = 4'b0111
	} alu_op_e;

	// funct3 codes used by the alu decode
	parameter logic [2:0] F3_ADD = 3'b000;
	parameter logic [2:0] F3_SLL = 3'b001;
	parameter logic [2:0] F3_SLT = 3'b010;
	parameter logic [2:0] F3_XOR = 3'b100;
	parameter logic [2:0] F3_SR  = 3'b101;
	parameter logic [2:0] F3_OR  = 3'b110;
	parameter logic [2:0] F3_AND = 3'b111;

endpackage

/* core_ifs.sv */
// decoded control bundle from decode to execute
interface ctrl_if;
	core_pkg::alu_op_e             alu_op;
	logic                          alu_src_imm;
	logic                          mem_we;
	logic                          mem_to_reg;
	logic                          reg_we;
	logic                          is_branch;
	logic                          is_halt;
	logic [core_pkg::XLEN-1:0]     imm;
	logic [core_pkg::REG_AW-1:0]   rd;

	modport master (output alu_op, alu_src_imm, mem_we, mem_to_reg, reg_we,
		is_branch, is_halt, imm, rd);
	modport slave (input alu_op, alu_src_imm, mem_we, mem_to_reg, reg_we,
		is_branch, is_halt, imm, rd);
endinterface

// register file read data and write-back port
interface rf_if;
	logic [core_pkg::XLEN-1:0]   rdata1;
	logic [core_pkg::XLEN-1:0]   rdata2;
	logic                        wr_en;
	logic [core_pkg::REG_AW-1:0] wr_addr;
	logic [core_pkg::XLEN-1:0]   wr_data;

	modport regs (output rdata1, rdata2, input wr_en, wr_addr, wr_data);
	modport exec (input rdata1, rdata2, output wr_en, wr_addr, wr_data);
endinterface

/* fetch_stage.sv */
module fetch_stage #(
	parameter int IMEM_WORDS = 256,
	localparam int IMEM_AW = $clog2(IMEM_WORDS)
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      run_i,
	input  logic                      imem_we_i,
	input  logic [IMEM_AW-1:0]        imem_addr_i,
	input  logic [core_pkg::XLEN-1:0] imem_wdata_i,
	input  logic                      redirect_i,
	input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
	input  logic                      halt_i,
	output logic [core_pkg::XLEN-1:0] instr_o,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                      valid_o
);

	logic [core_pkg::XLEN-1:0] pc_q;
	logic [core_pkg::XLEN-1:0] imem [IMEM_WORDS];
	logic [core_pkg::XLEN-1:0] instr_q;
	logic [core_pkg::XLEN-1:0] fpc_q;
	logic                      valid_q;
	logic                      fetch_en;

	// a redirect wins over a normal fetch in the same cycle
	assign fetch_en = run_i & ~halt_i & ~redirect_i;

	// program load port
	always_ff @(posedge clk) begin
		if (imem_we_i) begin
			imem[imem_addr_i] <= imem_wdata_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q    <= core_pkg::RESET_PC;
			valid_q <= 1'b0;
		end else if (redirect_i) begin
			// squash the word fetched alongside the redirecting instruction
			pc_q    <= redirect_pc_i;
			valid_q <= 1'b0;
		end else if (fetch_en) begin
			pc_q    <= pc_q + 32'd4;
			valid_q <= 1'b1;
		end else begin
			// stalled or halted, send a bubble
			valid_q <= 1'b0;
		end
	end

	// fetch register payload
	always_ff @(posedge clk) begin
		if (fetch_en) begin
			instr_q <= imem[pc_q[IMEM_AW+1:2]];
			fpc_q   <= pc_q;
		end
	end

	assign instr_o = instr_q;
	assign pc_o    = fpc_q;
	assign valid_o = valid_q;

endmodule

/* decode_unit.sv */
module decode_unit (
	input  logic [core_pkg::XLEN-1:0] instr_i,
	input  logic                      valid_i,
	ctrl_if.master                    ctrl
);

	core_pkg::opcode_e opcode;
	logic [2:0]        funct3;
	logic              funct7_b5;
	logic [core_pkg::XLEN-1:0] imm_i;
	logic [core_pkg::XLEN-1:0] imm_s;
	logic [core_pkg::XLEN-1:0] imm_b;

	assign opcode    = core_pkg::opcode_e'(instr_i[6:0]);
	assign funct3    = instr_i[14:12];
	assign funct7_b5 = instr_i[30];

	// sign-extended immediates
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};

	assign ctrl.rd = instr_i[11:7];

	// main control
	always_comb begin
		ctrl.alu_src_imm = 1'b0;
		ctrl.mem_we      = 1'b0;
		ctrl.mem_to_reg  = 1'b0;
		ctrl.reg_we      = 1'b0;
		ctrl.is_branch   = 1'b0;
		ctrl.is_halt     = 1'b0;
		ctrl.imm         = imm_i;
		if (valid_i) begin
			case (opcode)
				core_pkg::OP_REG: begin
					ctrl.reg_we = 1'b1;
				end
				core_pkg::OP_IMM: begin
					ctrl.reg_we      = 1'b1;
					ctrl.alu_src_imm = 1'b1;
				end
				core_pkg::OP_LOAD: begin
					ctrl.reg_we      = 1'b1;
					ctrl.mem_to_reg  = 1'b1;
					ctrl.alu_src_imm = 1'b1;
				end
				core_pkg::OP_STORE: begin
					ctrl.mem_we      = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					ctrl.imm         = imm_s;
				end
				core_pkg::OP_BRANCH: begin
					ctrl.is_branch = 1'b1;
					ctrl.imm       = imm_b;
				end
				core_pkg::OP_SYSTEM: begin
					ctrl.is_halt = 1'b1;
				end
				// unknown opcodes fall through as no-ops
				default: ;
			endcase
		end
	end

	// alu control from funct3 and funct7[5]
	always_comb begin
		ctrl.alu_op = core_pkg::ALU_ADD;
		if (opcode == core_pkg::OP_REG || opcode == core_pkg::OP_IMM) begin
			case (funct3)
				// only register form has sub, addi keeps bit 30 as immediate
				core_pkg::F3_ADD: ctrl.alu_op = (opcode == core_pkg::OP_REG && funct7_b5) ?
					core_pkg::ALU_SUB : core_pkg::ALU_ADD;
				core_pkg::F3_SLL: ctrl.alu_op = core_pkg::ALU_SLL;
				core_pkg::F3_SLT: ctrl.alu_op = core_pkg::ALU_SLT;
				core_pkg::F3_XOR: ctrl.alu_op = core_pkg::ALU_XOR;
				core_pkg::F3_SR:  ctrl.alu_op = funct7_b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
				core_pkg::F3_OR:  ctrl.alu_op = core_pkg::ALU_OR;
				core_pkg::F3_AND: ctrl.alu_op = core_pkg::ALU_AND;
				default:          ctrl.alu_op = core_pkg::ALU_ADD;
			endcase
		end
	end

endmodule

/* reg_file.sv */
module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [core_pkg::REG_AW-1:0] rs1_i,
	input  logic [core_pkg::REG_AW-1:0] rs2_i,
	rf_if.regs                          rf
);

	localparam int NREGS = 2 ** core_pkg::REG_AW;

	logic [core_pkg::XLEN-1:0] regs [NREGS];

	// x0 reads as zero whatever the array holds
	assign rf.rdata1 = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rf.rdata2 = (rs2_i == '0) ? '0 : regs[rs2_i];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.wr_en && rf.wr_addr != '0) begin
			regs[rf.wr_addr] <= rf.wr_data;
		end
	end

endmodule

/* exec_unit.sv */
module exec_unit #(
	parameter int DMEM_WORDS = 64,
	localparam int DMEM_AW = $clog2(DMEM_WORDS)
) (
	input  logic                        clk,
	input  logic                        rst_n,
	ctrl_if.slave                       ctrl,
	rf_if.exec                          rf,
	input  logic [core_pkg::XLEN-1:0]   pc_i,
	input  logic                        valid_i,
	output logic                        redirect_o,
	output logic [core_pkg::XLEN-1:0]   redirect_pc_o,
	output logic                        halt_o,
	output logic                        retire_valid_o,
	output logic [core_pkg::XLEN-1:0]   retire_pc_o,
	output logic [core_pkg::REG_AW-1:0] retire_rd_o,
	output logic [core_pkg::XLEN-1:0]   retire_data_o
);

	logic [core_pkg::XLEN-1:0] opb;
	logic [4:0]                shamt;
	logic [core_pkg::XLEN-1:0] alu_res;
	logic [core_pkg::XLEN-1:0] dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0]        dmem_idx;
	logic [core_pkg::XLEN-1:0] wb_data;
	logic                      wb_en;
	logic                      br_taken;
	logic                      halted_q;
	logic                      retire_valid_q;
	logic [core_pkg::XLEN-1:0] retire_pc_q;
	logic [core_pkg::REG_AW-1:0] retire_rd_q;
	logic [core_pkg::XLEN-1:0] retire_data_q;

	assign opb   = ctrl.alu_src_imm ? ctrl.imm : rf.rdata2;
	assign shamt = opb[4:0];

	always_comb begin
		alu_res = '0;
		case (ctrl.alu_op)
			core_pkg::ALU_ADD: alu_res = rf.rdata1 + opb;
			core_pkg::ALU_SUB: alu_res = rf.rdata1 - opb;
			core_pkg::ALU_AND: alu_res = rf.rdata1 & opb;
			core_pkg::ALU_OR:  alu_res = rf.rdata1 | opb;
			core_pkg::ALU_XOR: alu_res = rf.rdata1 ^ opb;
			core_pkg::ALU_SLT: alu_res[0] = $signed(rf.rdata1) < $signed(opb);
			core_pkg::ALU_SLL: alu_res = rf.rdata1 << shamt;
			core_pkg::ALU_SRL: alu_res = rf.rdata1 >> shamt;
			core_pkg::ALU_SRA: alu_res = $signed(rf.rdata1) >>> shamt;
			default:           alu_res = '0;
		endcase
	end

	// word index, wraps for a power-of-two depth
	assign dmem_idx = alu_res[DMEM_AW+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (ctrl.mem_we) begin
			dmem[dmem_idx] <= rf.rdata2;
		end
	end

	assign wb_data = ctrl.mem_to_reg ? dmem[dmem_idx] : alu_res;
	assign wb_en   = ctrl.reg_we && ctrl.rd != '0;

	assign rf.wr_en   = ctrl.reg_we;
	assign rf.wr_addr = ctrl.rd;
	assign rf.wr_data = wb_data;

	// ecall also redirects to itself so the word behind it is squashed
	assign br_taken      = ctrl.is_branch && rf.rdata1 == rf.rdata2;
	assign redirect_o    = br_taken | ctrl.is_halt;
	assign redirect_pc_o = ctrl.is_halt ? pc_i : pc_i + ctrl.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid_q <= 1'b0;
			halted_q       <= 1'b0;
		end else begin
			retire_valid_q <= valid_i;
			halted_q       <= halted_q | ctrl.is_halt;
		end
	end

	// retire record, rd and data read zero when nothing is written
	always_ff @(posedge clk) begin
		if (valid_i) begin
			retire_pc_q   <= pc_i;
			retire_rd_q   <= wb_en ? ctrl.rd : '0;
			retire_data_q <= wb_en ? wb_data : '0;
		end
	end

	assign halt_o         = halted_q;
	assign retire_valid_o = retire_valid_q;
	assign retire_pc_o    = retire_pc_q;
	assign retire_rd_o    = retire_rd_q;
	assign retire_data_o  = retire_data_q;

endmodule

/* core_top.sv */
module core_top #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 64,
	localparam int IMEM_AW = $clog2(IMEM_WORDS)
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run_i,
	input  logic                        imem_we_i,
	input  logic [IMEM_AW-1:0]          imem_addr_i,
	input  logic [core_pkg::XLEN-1:0]   imem_wdata_i,
	output logic                        retire_valid_o,
	output logic [core_pkg::XLEN-1:0]   retire_pc_o,
	output logic [core_pkg::REG_AW-1:0] retire_rd_o,
	output logic [core_pkg::XLEN-1:0]   retire_data_o,
	output logic                        halted_o
);

	logic [core_pkg::XLEN-1:0] instr;
	logic [core_pkg::XLEN-1:0] fetch_pc;
	logic                      fetch_valid;
	logic                      redirect;
	logic [core_pkg::XLEN-1:0] redirect_pc;

	ctrl_if ctrl_bus ();
	rf_if   rf_bus ();

	fetch_stage #(
		.IMEM_WORDS(IMEM_WORDS)
	) fetch_stage_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.run_i        (run_i),
		.imem_we_i    (imem_we_i),
		.imem_addr_i  (imem_addr_i),
		.imem_wdata_i (imem_wdata_i),
		.redirect_i   (redirect),
		.redirect_pc_i(redirect_pc),
		.halt_i       (halted_o),
		.instr_o      (instr),
		.pc_o         (fetch_pc),
		.valid_o      (fetch_valid)
	);

	decode_unit decode_unit_inst (
		.instr_i(instr),
		.valid_i(fetch_valid),
		.ctrl   (ctrl_bus)
	);

	// register reads straight from the rs fields of the fetched word
	reg_file reg_file_inst (
		.clk  (clk),
		.rst_n(rst_n),
		.rs1_i(instr[19:15]),
		.rs2_i(instr[24:20]),
		.rf   (rf_bus)
	);

	exec_unit #(
		.DMEM_WORDS(DMEM_WORDS)
	) exec_unit_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.ctrl          (ctrl_bus),
		.rf            (rf_bus),
		.pc_i          (fetch_pc),
		.valid_i       (fetch_valid),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.halt_o        (halted_o),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o   (retire_pc_o),
		.retire_rd_o   (retire_rd_o),
		.retire_data_o (retire_data_o)
	);

endmodule

/* tb_core.sv */
module tb_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMEM_WORDS   = 256;
	localparam int DMEM_WORDS   = 64;
	localparam int IMEM_AW      = $clog2(IMEM_WORDS);
	localparam int DMEM_AW      = $clog2(DMEM_WORDS);
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_PROGS    = 4;
	localparam int PROG_LEN     = 60;
	localparam int WATCHDOG_NS  = 3 * NUM_PROGS * PROG_LEN * CLK_PERIOD
		+ NUM_PROGS * RESET_CYCLES * CLK_PERIOD;

	logic               clk;
	logic               rst_n;
	logic               run_i;
	logic               imem_we_i;
	logic [IMEM_AW-1:0] imem_addr_i;
	logic [31:0]        imem_wdata_i;
	logic               retire_valid_o;
	logic [31:0]        retire_pc_o;
	logic [4:0]         retire_rd_o;
	logic [31:0]        retire_data_o;
	logic               halted_o;

	integer      seed = 32'h51fc_271b;
	logic [31:0] prog [PROG_LEN];
	// reference machine state
	logic [31:0] ref_regs [32];
	logic [31:0] ref_dmem [DMEM_WORDS];
	logic [31:0] ref_pc;
	logic        ref_halted;
	// expected retire stream in retire order
	logic [31:0] exp_pc_q [$];
	logic [4:0]  exp_rd_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] exp_pc;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	int          retire_count;

	core_top #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) core_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.run_i         (run_i),
		.imem_we_i     (imem_we_i),
		.imem_addr_i   (imem_addr_i),
		.imem_wdata_i  (imem_wdata_i),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o   (retire_pc_o),
		.retire_rd_o   (retire_rd_o),
		.retire_data_o (retire_data_o),
		.halted_o      (halted_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("CHECK FAILED time %0d ns: %s expected 0x%08h actual 0x%08h",
			$time, name, expected, actual);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic abort_run(string reason);
		$display("ERROR time %0d ns: %s", $time, reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic int rand_range(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// small register range so results feed later instructions
	function automatic logic [4:0] rand_reg();
		return 5'(rand_range(16));
	endfunction

	// alu funct3 codes of the subset without sltu
	function automatic logic [2:0] alu_funct3();
		logic [2:0] f3;
		f3 = 3'(rand_range(7));
		return (f3 >= 3'd3) ? f3 + 3'd1 : f3;
	endfunction

	function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_format(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic build_program();
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		logic [11:0] last_off;
		logic [12:0] off;
		logic [4:0]  rs1;
		int          kind;
		int          span;
		last_off = '0;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = rand_range(10);
			f3   = alu_funct3();
			// sub and sra set bit 30
			f7   = ((f3 == 3'd0 || f3 == 3'd5) && rand_range(2) == 0) ? 7'b0100000 : 7'b0;
			span = (PROG_LEN - 1 - i > 4) ? 4 : PROG_LEN - 1 - i;
			if (kind >= 8 && span < 2) begin
				kind = 3;
			end
			if (kind < 3) begin
				prog[i] = r_format(f7, rand_reg(), rand_reg(), f3, rand_reg());
			end else if (kind < 6) begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm = {f7, 5'(rand_range(32))};
				end else begin
					imm = 12'(rand_range(4096));
				end
				prog[i] = i_format(imm, rand_reg(), f3, rand_reg(), 7'b0010011);
			end else if (kind == 6) begin
				// half the loads hit the most recent store
				imm = (rand_range(2) == 0) ? last_off : 12'(rand_range(DMEM_WORDS) * 4);
				prog[i] = i_format(imm, 5'd0, 3'b010, rand_reg(), 7'b0000011);
			end else if (kind == 7) begin
				last_off = 12'(rand_range(DMEM_WORDS) * 4);
				prog[i]  = s_format(last_off, rand_reg(), 5'd0, 3'b010);
			end else begin
				// forward by at least 2 words and never past the ecall
				off = 13'((2 + rand_range(span - 1)) * 4);
				rs1 = rand_reg();
				prog[i] = b_format(off, (rand_range(2) == 0) ? rs1 : rand_reg(), rs1);
			end
		end
		prog[PROG_LEN-1] = 32'h0000_0073;
	endtask

	function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'b110: return a | b;
			3'b111: return a & b;
			default: return '0;
		endcase
	endfunction

	// executes the instruction at ref_pc
	function automatic void ref_step(output logic [31:0] pc, output logic [4:0] rd,
		output logic [31:0] data);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] res;
		logic [31:0] widx;
		logic        wr;
		ins    = prog[ref_pc[7:2]];
		pc     = ref_pc;
		a      = ref_regs[ins[19:15]];
		b      = ref_regs[ins[24:20]];
		imm_i  = {{20{ins[31]}}, ins[31:20]};
		res    = '0;
		wr     = 1'b0;
		ref_pc = ref_pc + 32'd4;
		case (ins[6:0])
			7'b0110011: begin
				wr  = 1'b1;
				res = alu_result(ins[14:12], ins[30], a, b);
			end
			7'b0010011: begin
				// bit 30 only selects srai since addi never subtracts
				wr  = 1'b1;
				res = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
			end
			7'b0000011: begin
				wr   = 1'b1;
				widx = ((a + imm_i) >> 2) % DMEM_WORDS;
				res  = ref_dmem[widx[DMEM_AW-1:0]];
			end
			7'b0100011: begin
				widx = ((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2) % DMEM_WORDS;
				ref_dmem[widx[DMEM_AW-1:0]] = b;
			end
			7'b1100011: begin
				if (a == b) begin
					ref_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			7'b1110011: ref_halted = 1'b1;
			default: ;
		endcase
		rd   = (wr && ins[11:7] != 5'd0) ? ins[11:7] : 5'd0;
		data = (rd != 5'd0) ? res : '0;
		if (rd != 5'd0) begin
			ref_regs[rd] = res;
		end
	endfunction

	// runs the reference up to the ecall and queues the retire stream
	task automatic predict();
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] data;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		for (int w = 0; w < DMEM_WORDS; w++) begin
			ref_dmem[w] = '0;
		end
		ref_pc     = '0;
		ref_halted = 1'b0;
		exp_pc_q.delete();
		exp_rd_q.delete();
		exp_data_q.delete();
		retire_count = 0;
		while (!ref_halted) begin
			ref_step(pc, rd, data);
			exp_pc_q.push_back(pc);
			exp_rd_q.push_back(rd);
			exp_data_q.push_back(data);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		run_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			imem_we_i    = 1'b1;
			imem_addr_i  = IMEM_AW'(i);
			imem_wdata_i = prog[i];
			@(posedge clk);
			#1;
		end
		imem_we_i = 1'b0;
	endtask

	task automatic run_program(logic stall);
		while (!halted_o) begin
			run_i = stall ? (rand_range(4) != 0) : 1'b1;
			@(posedge clk);
			#1;
		end
		// keep fetch requested so only the halt can stop it
		run_i = 1'b1;
		// step past the ecall retire cycle
		@(posedge clk);
		repeat (10) begin
			@(negedge clk);
			assert (!retire_valid_o) else abort_run("retirement seen after the core halted");
		end
		assert (exp_pc_q.size() == 0)
			else abort_run("core halted before retiring every reference instruction");
	endtask

	always @(negedge clk) begin
		if (rst_n && retire_valid_o) begin
			if (exp_pc_q.size() == 0) begin
				abort_run("core retired more instructions than the reference");
			end else begin
				exp_pc   = exp_pc_q.pop_front();
				exp_rd   = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				retire_count++;
				assert (retire_pc_o == exp_pc) else mismatch("retire_pc_o", exp_pc, retire_pc_o);
				assert (retire_rd_o == exp_rd)
					else mismatch("retire_rd_o", 32'(exp_rd), 32'(retire_rd_o));
				assert (retire_data_o == exp_data)
					else mismatch("retire_data_o", exp_data, retire_data_o);
				// halted rises together with the ecall as the last entry
				assert (halted_o == (exp_pc_q.size() == 0))
					else mismatch("halted_o", 32'(exp_pc_q.size() == 0), 32'(halted_o));
			end
		end
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		run_i        = 1'b0;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_wdata_i = '0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			apply_reset();
			build_program();
			load_program();
			predict();
			// odd programs drop run_i at random
			run_program(p % 2 == 1);
			$display("program %0d: %0d instructions retired", p, retire_count);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: core did not halt within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* compile.f */
core_pkg.sv
core_ifs.sv
fetch_stage.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
core_top.sv
tb_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
